// ==== rtl/progress_config.svh ====
`ifndef PROGRESS_CONFIG_SVH
`define PROGRESS_CONFIG_SVH

// Bus widths
`define PROGRESS_ADDR_W 32 // Address on bus B
`define PROGRESS_SEL_W 4 // Byte lanes, one per byte of a word
`define PROGRESS_WSEL_W 4 // Write mux code, microcode bits sa27..sa24

// Address regions, compared against the top bits of B
`define PROGRESS_IO_REGION 2'b01 // 0x4xxxxxxx to 0x7xxxxxxx is I/O
`define PROGRESS_CTRLREG_NIBBLE 4'b0010 // 0x2xxxxxxx holds the control registers

// Write mux codes that narrow the byte selects
`define PROGRESS_WSEL_HALF 4'b0001 // Halfword store
`define PROGRESS_WSEL_BYTE 4'b0010 // Byte store

`endif

// ==== rtl/progress_pkg.sv ====
`include "progress_config.svh"

package progress_pkg;

   // Address as seen on bus B
   typedef logic [`PROGRESS_ADDR_W-1:0] addr_t;

   // Byte lane vector, active high in SEL_O and active low in bmask
   typedef logic [`PROGRESS_SEL_W-1:0] sel_t;

   // Write mux code taken from the microcode word
   typedef logic [`PROGRESS_WSEL_W-1:0] wsel_t;

   // Acknowledge qualifier states
   // ACK_HELD is entered once ACK_I shows up with no strobe pending,
   // which is how a zero wait state slave with a tied ACK looks
   typedef enum logic {
      ACK_NORMAL = 1'b0, // ACK_I is honoured together with STB_O
      ACK_HELD   = 1'b1  // ACK_I disregarded, STB_O acts as its own ack
   } ack_state_e;

endpackage

// ==== rtl/bus_status_if.sv ====
`timescale 1ns/100ps

// Bus status shared by the strobe, ack, write enable and microcode blocks
interface bus_status_if;

   logic stb; // I/O strobe, STB_O
   logic sram_stb; // SRAM strobe
   logic q_ack; // Qualified I/O acknowledge
   logic we; // Write enable, WE_O
   logic badalign; // Misaligned word store or core halted

   // Strobe registers and alignment check
   modport strobe (output stb, output sram_stb, output badalign, input q_ack);

   // Acknowledge qualifier needs the I/O strobe only
   modport ack (output q_ack, input stb);

   // Write enable registers
   modport wr (output we, input badalign);

   // Microcode stall logic watches the transfer state
   modport prog (input stb, input sram_stb, input we);

endinterface

// ==== rtl/byte_select.sv ====
`timescale 1ns/100ps

`include "progress_config.svh"

// Byte selects for stores to SRAM, I/O and the register RAM
module byte_select (
   input  logic                clk,
   input  logic                RST_I,
   input  logic                sa41, // Latch byte selects
   input  progress_pkg::wsel_t wsel, // Store size from the write mux code
   input  logic [1:0]          adr_lo, // B[1:0]
   output progress_pkg::sel_t  SEL_O, // Active high byte selects
   output progress_pkg::sel_t  bmask // Same lanes, active low, for the register RAM
);

   progress_pkg::sel_t sel_d; // Decoded lanes, combinational

   always_comb begin
      sel_d = '1; // Word access by default
      case (wsel)
         `PROGRESS_WSEL_HALF: begin
            case (adr_lo)
               2'b00:   sel_d = 4'b0011; // Lower halfword
               2'b10:   sel_d = 4'b1100; // Upper halfword
               default: sel_d = '1; // Odd halfword address falls back to a word
            endcase
         end
         `PROGRESS_WSEL_BYTE: begin
            case (adr_lo)
               2'b00:   sel_d = 4'b0001;
               2'b01:   sel_d = 4'b0010;
               2'b10:   sel_d = 4'b0100;
               default: sel_d = 4'b1000;
            endcase
         end
         default: sel_d = '1;
      endcase
   end

   // Both copies load together so they never disagree
   always_ff @(posedge clk) begin
      if (RST_I) begin
         SEL_O <= '0; // No lanes selected
         bmask <= '1; // All lanes masked
      end else if (sa41) begin
         SEL_O <= sel_d;
         bmask <= ~sel_d;
      end
   end

endmodule

// ==== rtl/bus_strobe.sv ====
`timescale 1ns/100ps

`include "progress_config.svh"

// STB_O and sram_stb generation
// A strobe is raised the edge after sa42 and held until acknowledged
module bus_strobe (
   input  logic                clk,
   input  logic                RST_I,
   input  logic                corerunning, // No bus activity while halted
   input  logic                sa30, // Word store, must be word aligned
   input  logic                sa42, // Request a strobe
   input  logic                buserror, // Abort any transfer in flight
   input  logic                sram_ack, // SRAM acknowledge
   input  progress_pkg::addr_t adr, // Address on B
   bus_status_if.strobe        bus
);

   logic badalign;
   logic io_region; // Top two bits select I/O
   logic sram_region; // Top bit selects SRAM
   logic io_req;
   logic sram_req;
   logic stb_q;
   logic sram_stb_q;

   // A halfword store is not checked here, its address is settled earlier
   assign badalign = ~corerunning | (sa30 & (adr[1] | adr[0]));

   assign io_region   = adr[`PROGRESS_ADDR_W-1 -: 2] == `PROGRESS_IO_REGION;
   assign sram_region = adr[`PROGRESS_ADDR_W-1];

   assign io_req   = sa42 & io_region & ~badalign;
   assign sram_req = sa42 & sram_region & ~badalign;

   always_ff @(posedge clk) begin
      if (RST_I | buserror) begin
         stb_q      <= 1'b0;
         sram_stb_q <= 1'b0;
      end else begin
         // Set on request, hold until the matching ack is seen at an edge
         stb_q      <= io_req | (stb_q & ~bus.q_ack);
         sram_stb_q <= sram_req | (sram_stb_q & ~sram_ack);
      end
   end

   assign bus.stb      = stb_q;
   assign bus.sram_stb = sram_stb_q;
   assign bus.badalign = badalign; // Write enables apply the same refusal

endmodule

// ==== rtl/ack_qualifier.sv ====
`timescale 1ns/100ps

// Qualified acknowledge for the I/O bus
// A slave may keep ACK asserted when it is alone on the bus and has no
// wait states. Once ACK_I is seen without a strobe, ACK_I is ignored and
// each strobe acknowledges itself until ACK_I drops again.
module ack_qualifier (
   input  logic         clk,
   input  logic         RST_I,
   input  logic         ACK_I, // Acknowledge from the I/O device
   input  logic         sysregack, // Acknowledge from the system registers
   bus_status_if.ack    bus
);

   progress_pkg::ack_state_e state_q;
   progress_pkg::ack_state_e state_d;
   logic                     q_ack;

   always_comb begin
      state_d = state_q;
      q_ack   = sysregack; // System registers always acknowledge directly
      case (state_q)
         progress_pkg::ACK_NORMAL: begin
            q_ack = sysregack | (ACK_I & bus.stb);
            if (ACK_I & ~bus.stb) begin
               state_d = progress_pkg::ACK_HELD; // Stray ACK, assume a held one
            end
         end
         progress_pkg::ACK_HELD: begin
            q_ack = sysregack | bus.stb; // Zero wait state slave
            if (!ACK_I) begin
               state_d = progress_pkg::ACK_NORMAL; // ACK released, trust it again
            end
         end
         default: begin
            state_d = progress_pkg::ACK_NORMAL;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         state_q <= progress_pkg::ACK_NORMAL;
      end else begin
         state_q <= state_d;
      end
   end

   assign bus.q_ack = q_ack; // Combinational, ends STB_O in the same cycle

endmodule

// ==== rtl/write_enable.sv ====
`timescale 1ns/100ps

`include "progress_config.svh"

// WE_O and ctrlreg_we
// Loaded on sa43, cleared when the microcode drops sa14 at the end of a store
module write_enable (
   input  logic                clk,
   input  logic                RST_I,
   input  logic                sa14, // Low ends the store
   input  logic                sa43, // Possibly start a write
   input  logic                buserror,
   input  progress_pkg::addr_t adr, // Address on B
   bus_status_if.wr            bus,
   output logic                ctrlreg_we // Write to control registers in register RAM space
);

   logic clr; // Clear wins over load
   logic we_d;
   logic ctrlreg_we_d;
   logic we_q;

   assign clr = ~sa14 | RST_I | buserror;

   // SRAM or I/O, anything with one of the two top bits set
   assign we_d = (adr[`PROGRESS_ADDR_W-1] | adr[`PROGRESS_ADDR_W-2]) & ~bus.badalign;

   // 0x2xxxxxxx
   assign ctrlreg_we_d = (adr[`PROGRESS_ADDR_W-1 -: 4] == `PROGRESS_CTRLREG_NIBBLE)
                         & ~bus.badalign;

   always_ff @(posedge clk) begin
      if (clr) begin
         we_q       <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (sa43) begin
         we_q       <= we_d;
         ctrlreg_we <= ctrlreg_we_d;
      end
   end

   assign bus.we = we_q;

endmodule

// ==== rtl/ucode_progress.sv ====
`timescale 1ns/100ps

// Stall logic for the microcode sequencer, Q register and register RAM
module ucode_progress (
   input  logic          corerunning, // Block register writes before the core starts
   input  logic          sa15, // Part of the Q enable
   input  logic          sa32, // Part of the Q enable, read input
   input  logic          sa33, // Repeat shift until the shift count is zero
   input  logic          sa41, // Byte select setup cycle, no register write
   input  logic          lastshift,
   input  logic          rlastshift, // Registered lastshift
   input  logic          buserror, // Forces forward progress
   bus_status_if.prog    bus,
   output logic          enaQ, // Q samples the ALU
   output logic          progress_ucode, // Microcode may advance
   output logic          iwe // Register RAM write enable
);

   logic busy; // A transfer is waiting for its ack
   logic shift_done;
   logic avoid_iwe;

   assign busy = bus.stb | bus.sram_stb;

   // Not in a shift loop, or the loop is on its last step
   assign shift_done = ~sa33 | lastshift | rlastshift;

   assign enaQ = (sa15 | sa32) & ~lastshift & ~busy;

   // A bus error must never leave the sequencer stuck
   assign progress_ucode = (shift_done & ~busy) | buserror;

   // External writes and zero length shifts must not touch the register RAM
   assign avoid_iwe = sa41 | bus.we | rlastshift;
   assign iwe       = corerunning & ~avoid_iwe;

endmodule

// ==== rtl/progress_ctrl.sv ====
`timescale 1ns/100ps

// Bus progress controller of the serial core
module progress_ctrl (
   input  logic        clk,
   input  logic        RST_I,
   input  logic        corerunning,
   input  logic        ACK_I, // I/O acknowledge
   input  logic        sram_ack, // SRAM acknowledge
   input  logic        sysregack, // System register acknowledge
   input  logic        buserror,
   input  logic        sa14, // Needed to end a write
   input  logic        sa15, // Q enable
   input  logic        sa30, // Word store
   input  logic        sa32, // Q enable, read input
   input  logic        sa33, // Shift loop
   input  logic        sa41, // Latch byte selects
   input  logic        sa42, // Strobe request
   input  logic        sa43, // Write request
   input  logic        lastshift,
   input  logic        rlastshift,
   input  logic [3:0]  wsel, // sa27..sa24
   input  logic [31:0] B, // Address
   output logic [3:0]  SEL_O,
   output logic [3:0]  bmask,
   output logic        iwe,
   output logic        ctrlreg_we,
   output logic        WE_O,
   output logic        STB_O,
   output logic        sram_stb,
   output logic        enaQ,
   output logic        progress_ucode,
   output logic        qACK
);

   bus_status_if bus0 ();

   byte_select u_byte_select (
      .clk    (clk),
      .RST_I  (RST_I),
      .sa41   (sa41),
      .wsel   (wsel),
      .adr_lo (B[1:0]),
      .SEL_O  (SEL_O),
      .bmask  (bmask)
   );

   bus_strobe u_bus_strobe (
      .clk         (clk),
      .RST_I       (RST_I),
      .corerunning (corerunning),
      .sa30        (sa30),
      .sa42        (sa42),
      .buserror    (buserror),
      .sram_ack    (sram_ack),
      .adr         (B),
      .bus         (bus0.strobe)
   );

   ack_qualifier u_ack_qualifier (
      .clk       (clk),
      .RST_I     (RST_I),
      .ACK_I     (ACK_I),
      .sysregack (sysregack),
      .bus       (bus0.ack)
   );

   write_enable u_write_enable (
      .clk        (clk),
      .RST_I      (RST_I),
      .sa14       (sa14),
      .sa43       (sa43),
      .buserror   (buserror),
      .adr        (B),
      .bus        (bus0.wr),
      .ctrlreg_we (ctrlreg_we)
   );

   ucode_progress u_ucode_progress (
      .corerunning    (corerunning),
      .sa15           (sa15),
      .sa32           (sa32),
      .sa33           (sa33),
      .sa41           (sa41),
      .lastshift      (lastshift),
      .rlastshift     (rlastshift),
      .buserror       (buserror),
      .bus            (bus0.prog),
      .enaQ           (enaQ),
      .progress_ucode (progress_ucode),
      .iwe            (iwe)
   );

   // Bus status out to the pins
   assign STB_O    = bus0.stb;
   assign sram_stb = bus0.sram_stb;
   assign WE_O     = bus0.we;
   assign qACK     = bus0.q_ack;

endmodule

// ==== verif/progress_ctrl_tb.sv ====
`timescale 1ns/100ps

// Testbench for progress_ctrl, one table row per clock cycle
module progress_ctrl_tb;

   logic        clk;
   logic        RST_I;
   logic        corerunning, ACK_I, sram_ack, sysregack, buserror;
   logic        sa14, sa15, sa30, sa32, sa33, sa41, sa42, sa43;
   logic        lastshift, rlastshift;
   logic [3:0]  wsel;
   logic [31:0] B;
   logic [3:0]  SEL_O, bmask;
   logic        iwe, ctrlreg_we, WE_O, STB_O, sram_stb, enaQ, progress_ucode, qACK;

   // Stimulus table, filled by add_row
   bit          rnd_q[$]; // Address comes from $random
   logic [14:0] ctl_q[$];
   logic [3:0]  wsel_q[$];
   logic [31:0] adr_q[$];
   logic [11:0] exp_q[$];

   bit     table_ready;
   integer seed;
   int     errors;
   int     checks;

   progress_ctrl dut0 (
      .clk (clk), .RST_I (RST_I), .corerunning (corerunning), .ACK_I (ACK_I),
      .sram_ack (sram_ack), .sysregack (sysregack), .buserror (buserror),
      .sa14 (sa14), .sa15 (sa15), .sa30 (sa30), .sa32 (sa32), .sa33 (sa33),
      .sa41 (sa41), .sa42 (sa42), .sa43 (sa43),
      .lastshift (lastshift), .rlastshift (rlastshift), .wsel (wsel), .B (B),
      .SEL_O (SEL_O), .bmask (bmask), .iwe (iwe), .ctrlreg_we (ctrlreg_we),
      .WE_O (WE_O), .STB_O (STB_O), .sram_stb (sram_stb), .enaQ (enaQ),
      .progress_ucode (progress_ucode), .qACK (qACK)
   );

   always #10 clk = ~clk; // 20 ns period

   task automatic add_row(input bit rnd, input logic [14:0] ctl, input logic [3:0] ws,
                          input logic [31:0] adr, input logic [11:0] exp_v);
      rnd_q.push_back(rnd);
      ctl_q.push_back(ctl);
      wsel_q.push_back(ws);
      adr_q.push_back(adr);
      exp_q.push_back(exp_v);
   endtask

   // Control columns: run ack sack sysack berr _ sa14 sa15 sa30 sa32 sa33 _ sa41 sa42 sa43 last rlast
   // Expected columns: SEL_O _ iwe ctrlreg_we WE_O STB_O sram_stb _ enaQ progress_ucode qACK
   task automatic build_table();
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b0000_10000_010); // Reset values
      add_row(1'b0, 15'b10000_10000_10000, 4'h1, 32'h0000_0000, 12'b0000_00000_010); // Half at 00
      add_row(1'b0, 15'b10000_10000_10000, 4'h1, 32'h0000_0002, 12'b0011_00000_010); // Half at 10
      add_row(1'b0, 15'b10000_10000_10000, 4'h2, 32'h0000_0000, 12'b1100_00000_010); // Byte lanes
      add_row(1'b0, 15'b10000_10000_10000, 4'h2, 32'h0000_0001, 12'b0001_00000_010);
      add_row(1'b0, 15'b10000_10000_10000, 4'h2, 32'h0000_0002, 12'b0010_00000_010);
      add_row(1'b0, 15'b10000_10000_10000, 4'h2, 32'h0000_0003, 12'b0100_00000_010);
      add_row(1'b0, 15'b10000_10000_10000, 4'h4, 32'h0000_0001, 12'b1000_00000_010); // Other code
      add_row(1'b0, 15'b10000_10000_00000, 4'h1, 32'h0000_0000, 12'b1111_10000_010); // No sa41
      add_row(1'b1, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010); // Holds
      // I/O request, three stalled cycles, then ACK_I
      add_row(1'b0, 15'b10000_11000_01000, 4'h0, 32'h4000_0010, 12'b1111_10000_110);
      add_row(1'b0, 15'b10000_11000_00000, 4'h0, 32'h4000_0010, 12'b1111_10010_000);
      add_row(1'b0, 15'b10000_11000_00000, 4'h0, 32'h4000_0010, 12'b1111_10010_000);
      add_row(1'b0, 15'b10000_11000_00000, 4'h0, 32'h4000_0010, 12'b1111_10010_000);
      add_row(1'b0, 15'b11000_11000_00000, 4'h0, 32'h4000_0010, 12'b1111_10010_001);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      // SRAM request and sram_ack
      add_row(1'b0, 15'b10000_10000_01000, 4'h0, 32'h8000_0100, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h8000_0100, 12'b1111_10001_000);
      add_row(1'b0, 15'b10100_10000_00000, 4'h0, 32'h8000_0100, 12'b1111_10001_000);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10100_01000, 4'h0, 32'h8000_0002, 12'b1111_10000_010); // Misaligned
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b00000_10000_01000, 4'h0, 32'h4000_0000, 12'b1111_00000_010); // Halted
      add_row(1'b0, 15'b00000_10000_00000, 4'h0, 32'h4000_0000, 12'b1111_00000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_01000, 4'h0, 32'h8000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h8000_0000, 12'b1111_10001_000);
      add_row(1'b0, 15'b10001_10000_00000, 4'h0, 32'h8000_0000, 12'b1111_10001_010); // buserror
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      // Write enables, 0x2 is control registers only, 0xC is an external write
      add_row(1'b0, 15'b10000_10000_00100, 4'h0, 32'h2000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h2000_0000, 12'b1111_11000_010);
      add_row(1'b0, 15'b10000_00000_00000, 4'h0, 32'h2000_0000, 12'b1111_11000_010); // sa14 low
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00100, 4'h0, 32'hC000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'hC000_0000, 12'b1111_00100_010);
      add_row(1'b0, 15'b10000_00000_00000, 4'h0, 32'hC000_0000, 12'b1111_00100_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_00000_00100, 4'h0, 32'hC000_0000, 12'b1111_10000_010); // Clear wins
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      // Held ACK_I, then released
      add_row(1'b0, 15'b11000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b11010_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_011);
      add_row(1'b0, 15'b11000_10000_01000, 4'h0, 32'h4000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h4000_0000, 12'b1111_10010_001); // Self ack
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_01000, 4'h0, 32'h4000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h4000_0000, 12'b1111_10010_000);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h4000_0000, 12'b1111_10010_000);
      add_row(1'b0, 15'b11000_10000_00000, 4'h0, 32'h4000_0000, 12'b1111_10010_001);
      add_row(1'b0, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10010_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_011);
      add_row(1'b1, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      // Shift loop stalls on an idle bus
      add_row(1'b0, 15'b10000_11001_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_100);
      add_row(1'b0, 15'b10000_11001_00010, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b0, 15'b10000_11001_00001, 4'h0, 32'h0000_0000, 12'b1111_00000_110);
      add_row(1'b0, 15'b10000_10010_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_110);
      add_row(1'b1, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
      add_row(1'b1, 15'b10000_10000_00000, 4'h0, 32'h0000_0000, 12'b1111_10000_010);
   endtask

   task automatic drive_row(input int i);
      logic [31:0] adr;
      adr = adr_q[i];
      if (rnd_q[i]) begin
         adr = $random(seed);
         adr[31:29] = 3'b000; // Outside I/O, SRAM and control registers
      end
      {corerunning, ACK_I, sram_ack, sysregack, buserror, sa14, sa15, sa30, sa32, sa33,
       sa41, sa42, sa43, lastshift, rlastshift} = ctl_q[i];
      wsel = wsel_q[i];
      B    = adr;
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp_v);
      checks++;
      if (got !== exp_v) begin
         errors++;
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp_v);
      end
   endtask

   task automatic check_row(input int i);
      logic [11:0] e;
      logic [3:0]  mask_n; // bmask is always the inverse of the lanes
      e      = exp_q[i];
      mask_n = ~e[11:8];
      check_val("SEL_O", 32'(SEL_O), 32'(e[11:8]));
      check_val("bmask", 32'(bmask), 32'(mask_n));
      check_val("iwe", 32'(iwe), 32'(e[7]));
      check_val("ctrlreg_we", 32'(ctrlreg_we), 32'(e[6]));
      check_val("WE_O", 32'(WE_O), 32'(e[5]));
      check_val("STB_O", 32'(STB_O), 32'(e[4]));
      check_val("sram_stb", 32'(sram_stb), 32'(e[3]));
      check_val("enaQ", 32'(enaQ), 32'(e[2]));
      check_val("progress_ucode", 32'(progress_ucode), 32'(e[1]));
      check_val("qACK", 32'(qACK), 32'(e[0]));
   endtask

   // Watchdog, two clock periods per row plus margin
   initial begin
      wait (table_ready);
      #(ctl_q.size() * 40 + 1000);
      $display("Timeout: the table did not complete in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      clk = 1'b0;
      RST_I = 1'b1;
      {corerunning, sa14} = 2'b11; // Idle core, store not ending
      {ACK_I, sram_ack, sysregack, buserror, sa15, sa30, sa32, sa33} = '0;
      {sa41, sa42, sa43, lastshift, rlastshift} = '0;
      wsel = '0;
      B = '0;
      seed = 32'ha8da;
      errors = 0;
      checks = 0;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      #2 RST_I = 1'b0;
      for (int i = 0; i < ctl_q.size(); i++) begin
         @(posedge clk);
         #2 drive_row(i);
         #16 check_row(i); // Just before the next edge
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/progress_pkg.sv
rtl/bus_status_if.sv
rtl/byte_select.sv
rtl/bus_strobe.sv
rtl/ack_qualifier.sv
rtl/write_enable.sv
rtl/ucode_progress.sv
rtl/progress_ctrl.sv
verif/progress_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the progress_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
   --top-module progress_ctrl_tb -Mdir obj_dir -o progress_ctrl_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/progress_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
   exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1
